/* rtl/exec_settings.svh */
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// ********************
// Datapath widths
// ********************

// Integer register width
`define XLEN        32

// Program counter width
`define PC_BITS     32

// ********************
// Multiplier
// ********************

`define MUL_STEPS   `XLEN   // Upper bound on shift-add steps

`endif

/* rtl/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    // ********************
    // Micro-op fields
    // ********************

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [2:0] {
        OPND_ZERO, OPND_RS1, OPND_RS2, OPND_IMM, OPND_PC
    } opnd_sel_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE,
        BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
    } br_op_e;

    typedef enum logic [1:0] {
        WB_ALU, WB_OP1, WB_LINK, WB_MUL   // Write-back source
    } wb_sel_e;

    // ********************
    // Multiplier FSM
    // ********************

    typedef enum logic [1:0] {
        MUL_IDLE, MUL_RUN, MUL_DONE
    } mul_state_e;

endpackage

`default_nettype wire

/* rtl/uop_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

module uop_decode (
    input  wire                         uop_valid_i,
    input  wire [`PC_BITS-1:0]          uop_pc_i,
    input  wire [`XLEN-1:0]             uop_rs1_i,
    input  wire [`XLEN-1:0]             uop_rs2_i,
    input  wire [`XLEN-1:0]             uop_imm_i,
    input  wire exec_pkg::opnd_sel_e    uop_op1_sel_i,
    input  wire exec_pkg::opnd_sel_e    uop_op2_sel_i,
    input  wire exec_pkg::br_op_e       uop_br_op_i,
    input  wire exec_pkg::wb_sel_e      uop_wb_sel_i,
    output logic [`XLEN-1:0]            op1_o,
    output logic [`XLEN-1:0]            op2_o,
    output logic [`PC_BITS-1:0]         br_base_o,
    output logic                        mul_start_o
);

function automatic logic [`XLEN-1:0] pick_operand(
    input exec_pkg::opnd_sel_e  sel,
    input logic [`XLEN-1:0]     rs1,
    input logic [`XLEN-1:0]     rs2,
    input logic [`XLEN-1:0]     imm,
    input logic [`PC_BITS-1:0]  pc
);
    case (sel)
        exec_pkg::OPND_RS1: pick_operand = rs1;
        exec_pkg::OPND_RS2: pick_operand = rs2;
        exec_pkg::OPND_IMM: pick_operand = imm;
        exec_pkg::OPND_PC:  pick_operand = `XLEN'(pc);
        default:            pick_operand = '0;     // OPND_ZERO
    endcase
endfunction

assign op1_o = pick_operand(uop_op1_sel_i, uop_rs1_i, uop_rs2_i, uop_imm_i, uop_pc_i);
assign op2_o = pick_operand(uop_op2_sel_i, uop_rs1_i, uop_rs2_i, uop_imm_i, uop_pc_i);

// JALR jumps relative to rs1, the rest relative to the PC
assign br_base_o = (uop_br_op_i == exec_pkg::BR_JALR) ? `PC_BITS'(uop_rs1_i) : uop_pc_i;

assign mul_start_o = uop_valid_i && (uop_wb_sel_i == exec_pkg::WB_MUL);

endmodule

`default_nettype wire

/* rtl/alu.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

module alu (
    input  wire exec_pkg::alu_op_e      op_i,
    input  wire [`XLEN-1:0]             a_i,
    input  wire [`XLEN-1:0]             b_i,
    output logic [`XLEN-1:0]            result_o,
    output logic                        eq_o,
    output logic                        lt_o,
    output logic                        ltu_o
);

localparam int SHAMT_W = $clog2(`XLEN);

logic [SHAMT_W-1:0]     shamt;
logic [`XLEN-1:0]       sum;
logic [`XLEN-1:0]       diff;

assign shamt = b_i[SHAMT_W-1:0];    // Low five bits only
assign sum   = a_i + b_i;
assign diff  = a_i - b_i;

// ********************
// Comparison flags
// ********************

assign eq_o  = (a_i == b_i);
assign lt_o  = ($signed(a_i) < $signed(b_i));
assign ltu_o = (a_i < b_i);

// ********************
// Result
// ********************

always_comb begin
    case (op_i)
        exec_pkg::ALU_ADD:  result_o = sum;
        exec_pkg::ALU_SUB:  result_o = diff;
        exec_pkg::ALU_AND:  result_o = a_i & b_i;
        exec_pkg::ALU_OR:   result_o = a_i | b_i;
        exec_pkg::ALU_XOR:  result_o = a_i ^ b_i;
        exec_pkg::ALU_SLL:  result_o = a_i << shamt;
        exec_pkg::ALU_SRL:  result_o = a_i >> shamt;
        exec_pkg::ALU_SRA:  result_o = `XLEN'($signed(a_i) >>> shamt);
        exec_pkg::ALU_SLT:  result_o = {{(`XLEN-1){1'b0}}, lt_o};
        exec_pkg::ALU_SLTU: result_o = {{(`XLEN-1){1'b0}}, ltu_o};
        default:            result_o = sum;
    endcase
end

endmodule

`default_nettype wire

/* rtl/mul_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

module mul_unit (
    input  wire                         clk_i,
    input  wire                         rstn_i,
    input  wire                         start_i,
    input  wire                         hold_i,
    input  wire [`XLEN-1:0]             a_i,
    input  wire [`XLEN-1:0]             b_i,
    output logic [`XLEN-1:0]            product_o,
    output logic                        stall_o
);

localparam int CNT_W = $clog2(`MUL_STEPS);

exec_pkg::mul_state_e   state_q;
logic [CNT_W-1:0]       step_q;
logic [`XLEN-1:0]       mcand_q;
logic [`XLEN-1:0]       mplier_q;
logic [`XLEN-1:0]       acc_q;
logic                   last_step;

// Stop early once no multiplier bits are left
assign last_step = (mplier_q[`XLEN-1:1] == '0) || (step_q == CNT_W'(`MUL_STEPS - 1));

// ********************
// Control FSM
// ********************

always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
        state_q <= exec_pkg::MUL_IDLE;
        step_q  <= '0;
    end else begin
        case (state_q)
            exec_pkg::MUL_IDLE: begin
                step_q <= '0;
                if (start_i) state_q <= exec_pkg::MUL_RUN;
            end
            exec_pkg::MUL_RUN: begin
                step_q <= step_q + 1'b1;
                if (!start_i) state_q <= exec_pkg::MUL_IDLE;     // Uop withdrawn
                else if (last_step) state_q <= exec_pkg::MUL_DONE;
            end
            exec_pkg::MUL_DONE: begin
                if (!hold_i) state_q <= exec_pkg::MUL_IDLE;      // Product captured
            end
            default: state_q <= exec_pkg::MUL_IDLE;
        endcase
    end
end

// ********************
// Shift-add datapath
// ********************

always_ff @(posedge clk_i) begin
    if (state_q == exec_pkg::MUL_IDLE && start_i) begin
        mcand_q  <= a_i;
        mplier_q <= b_i;
        acc_q    <= '0;
    end else if (state_q == exec_pkg::MUL_RUN) begin
        if (mplier_q[0]) acc_q <= acc_q + mcand_q;
        mcand_q  <= mcand_q << 1;
        mplier_q <= mplier_q >> 1;
    end
end

assign stall_o   = start_i && (state_q != exec_pkg::MUL_DONE);
assign product_o = acc_q;   // Low half only

endmodule

`default_nettype wire

/* rtl/branch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

module branch_unit (
    input  wire                         uop_valid_i,
    input  wire exec_pkg::br_op_e       br_op_i,
    input  wire [`PC_BITS-1:0]          pc_i,
    input  wire [`PC_BITS-1:0]          base_i,
    input  wire [`XLEN-1:0]             imm_i,
    input  wire                         pred_taken_i,
    input  wire                         eq_i,
    input  wire                         lt_i,
    input  wire                         ltu_i,
    output logic [`XLEN-1:0]            link_o,
    output logic                        flush_o,
    output logic [`PC_BITS-1:0]         redirect_pc_o,
    output logic                        bp_update_o,
    output logic [`PC_BITS-1:0]         bp_pc_o,
    output logic [`PC_BITS-1:0]         bp_target_o,
    output logic                        bp_taken_o
);

logic [`PC_BITS-1:0]    sum;
logic [`PC_BITS-1:0]    target;
logic [`PC_BITS-1:0]    link_pc;
logic                   taken;

assign sum     = base_i + `PC_BITS'(imm_i);
assign target  = (br_op_i == exec_pkg::BR_JALR) ? {sum[`PC_BITS-1:1], 1'b0} : sum;
assign link_pc = pc_i + `PC_BITS'(4);
assign link_o  = `XLEN'(link_pc);

always_comb begin
    case (br_op_i)
        exec_pkg::BR_BEQ:  taken = eq_i;
        exec_pkg::BR_BNE:  taken = !eq_i;
        exec_pkg::BR_BLT:  taken = lt_i;
        exec_pkg::BR_BGE:  taken = !lt_i;
        exec_pkg::BR_BLTU: taken = ltu_i;
        exec_pkg::BR_BGEU: taken = !ltu_i;
        exec_pkg::BR_JAL,
        exec_pkg::BR_JALR: taken = 1'b1;
        default:           taken = 1'b0;
    endcase
end

// ********************
// Redirect and feedback
// ********************

assign flush_o       = uop_valid_i && (taken != pred_taken_i);
assign redirect_pc_o = taken ? target : link_pc;    // Not-taken resumes at PC+4

assign bp_update_o = uop_valid_i && (br_op_i != exec_pkg::BR_NONE);
assign bp_pc_o     = pc_i;
assign bp_target_o = target;
assign bp_taken_o  = taken;

endmodule

`default_nettype wire

/* rtl/exec_result.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

module exec_result (
    input  wire                         clk_i,
    input  wire                         rstn_i,
    input  wire                         uop_valid_i,
    input  wire                         stall_i,
    input  wire                         hold_i,
    input  wire                         flush_i,
    input  wire exec_pkg::wb_sel_e      wb_sel_i,
    input  wire [`PC_BITS-1:0]          pc_i,
    input  wire [`XLEN-1:0]             rs2_i,
    input  wire [`XLEN-1:0]             alu_i,
    input  wire [`XLEN-1:0]             op1_i,
    input  wire [`XLEN-1:0]             link_i,
    input  wire [`XLEN-1:0]             product_i,
    output logic                        mem_valid_o,
    output logic [`PC_BITS-1:0]         mem_pc_o,
    output logic [`XLEN-1:0]            mem_result_o,
    output logic [`XLEN-1:0]            mem_rs2_o,
    output logic [`XLEN-1:0]            mem_alu_o
);

logic [`XLEN-1:0]   wb_data;

always_comb begin
    case (wb_sel_i)
        exec_pkg::WB_OP1:  wb_data = op1_i;
        exec_pkg::WB_LINK: wb_data = link_i;
        exec_pkg::WB_MUL:  wb_data = product_i;
        default:           wb_data = alu_i;
    endcase
end

// ********************
// Register toward memory
// ********************

always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
        mem_valid_o <= 1'b0;
    end else if (flush_i) begin
        mem_valid_o <= 1'b0;                        // Flush beats hold
    end else if (!hold_i) begin
        mem_valid_o <= uop_valid_i && !stall_i;     // Bubble while multiplying
    end
end

always_ff @(posedge clk_i) begin
    if (!hold_i) begin
        mem_pc_o     <= pc_i;
        mem_result_o <= wb_data;
        mem_rs2_o    <= rs2_i;                      // Store data
        mem_alu_o    <= alu_i;                      // Load/store address
    end
end

endmodule

`default_nettype wire

/* rtl/exec_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

module exec_stage (
    input  wire                         clk_i,
    input  wire                         rstn_i,
    input  wire                         uop_valid_i,
    input  wire [`PC_BITS-1:0]          uop_pc_i,
    input  wire [`XLEN-1:0]             uop_rs1_i,
    input  wire [`XLEN-1:0]             uop_rs2_i,
    input  wire [`XLEN-1:0]             uop_imm_i,
    input  wire exec_pkg::alu_op_e      uop_alu_op_i,
    input  wire exec_pkg::opnd_sel_e    uop_op1_sel_i,
    input  wire exec_pkg::opnd_sel_e    uop_op2_sel_i,
    input  wire exec_pkg::br_op_e       uop_br_op_i,
    input  wire                         uop_pred_taken_i,
    input  wire exec_pkg::wb_sel_e      uop_wb_sel_i,
    input  wire                         hold_i,
    input  wire                         flush_i,
    output logic                        stall_o,
    output logic                        flush_o,
    output logic [`PC_BITS-1:0]         redirect_pc_o,
    output logic                        bp_update_o,
    output logic [`PC_BITS-1:0]         bp_pc_o,
    output logic [`PC_BITS-1:0]         bp_target_o,
    output logic                        bp_taken_o,
    output logic                        mem_valid_o,
    output logic [`PC_BITS-1:0]         mem_pc_o,
    output logic [`XLEN-1:0]            mem_result_o,
    output logic [`XLEN-1:0]            mem_rs2_o,
    output logic [`XLEN-1:0]            mem_alu_o
);

logic [`XLEN-1:0]       op1;
logic [`XLEN-1:0]       op2;
logic [`PC_BITS-1:0]    br_base;
logic                   mul_start;
logic [`XLEN-1:0]       alu_result;
logic                   alu_eq;
logic                   alu_lt;
logic                   alu_ltu;
logic [`XLEN-1:0]       product;
logic [`XLEN-1:0]       link;

uop_decode u_decode (
    .uop_valid_i    (uop_valid_i),
    .uop_pc_i       (uop_pc_i),
    .uop_rs1_i      (uop_rs1_i),
    .uop_rs2_i      (uop_rs2_i),
    .uop_imm_i      (uop_imm_i),
    .uop_op1_sel_i  (uop_op1_sel_i),
    .uop_op2_sel_i  (uop_op2_sel_i),
    .uop_br_op_i    (uop_br_op_i),
    .uop_wb_sel_i   (uop_wb_sel_i),
    .op1_o          (op1),
    .op2_o          (op2),
    .br_base_o      (br_base),
    .mul_start_o    (mul_start)
);

alu u_alu (
    .op_i       (uop_alu_op_i),
    .a_i        (op1),
    .b_i        (op2),
    .result_o   (alu_result),
    .eq_o       (alu_eq),
    .lt_o       (alu_lt),
    .ltu_o      (alu_ltu)
);

mul_unit u_mul (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .start_i    (mul_start),
    .hold_i     (hold_i),
    .a_i        (op1),
    .b_i        (op2),
    .product_o  (product),
    .stall_o    (stall_o)
);

branch_unit u_branch (
    .uop_valid_i    (uop_valid_i),
    .br_op_i        (uop_br_op_i),
    .pc_i           (uop_pc_i),
    .base_i         (br_base),
    .imm_i          (uop_imm_i),
    .pred_taken_i   (uop_pred_taken_i),
    .eq_i           (alu_eq),
    .lt_i           (alu_lt),
    .ltu_i          (alu_ltu),
    .link_o         (link),
    .flush_o        (flush_o),
    .redirect_pc_o  (redirect_pc_o),
    .bp_update_o    (bp_update_o),
    .bp_pc_o        (bp_pc_o),
    .bp_target_o    (bp_target_o),
    .bp_taken_o     (bp_taken_o)
);

exec_result u_result (
    .clk_i          (clk_i),
    .rstn_i         (rstn_i),
    .uop_valid_i    (uop_valid_i),
    .stall_i        (stall_o),
    .hold_i         (hold_i),
    .flush_i        (flush_i),
    .wb_sel_i       (uop_wb_sel_i),
    .pc_i           (uop_pc_i),
    .rs2_i          (uop_rs2_i),
    .alu_i          (alu_result),
    .op1_i          (op1),
    .link_i         (link),
    .product_i      (product),
    .mem_valid_o    (mem_valid_o),
    .mem_pc_o       (mem_pc_o),
    .mem_result_o   (mem_result_o),
    .mem_rs2_o      (mem_rs2_o),
    .mem_alu_o      (mem_alu_o)
);

endmodule

`default_nettype wire

/* bench/exec_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_clock (
    output logic clk_o,
    output logic rstn_o
);

initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;     // 40 ns period
end

initial begin
    rstn_o = 1'b0;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    rstn_o = 1'b1;                  // Release away from the active edge
end

endmodule

`default_nettype wire

/* bench/exec_stage_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

module exec_stage_tb;

localparam int NUM_OPS   = 90;
localparam int MAX_LAT   = `MUL_STEPS + 4;
localparam int CYCLE_MAX = NUM_OPS * MAX_LAT * 2;

logic                   clk;
logic                   rstn;
logic                   uop_valid;
logic [`PC_BITS-1:0]    uop_pc;
logic [`XLEN-1:0]       uop_rs1;
logic [`XLEN-1:0]       uop_rs2;
logic [`XLEN-1:0]       uop_imm;
exec_pkg::alu_op_e      uop_alu_op;
exec_pkg::opnd_sel_e    uop_op1_sel;
exec_pkg::opnd_sel_e    uop_op2_sel;
exec_pkg::br_op_e       uop_br_op;
logic                   uop_pred_taken;
exec_pkg::wb_sel_e      uop_wb_sel;
logic                   hold;
logic                   flush_in;
logic                   stall_o;
logic                   flush_o;
logic [`PC_BITS-1:0]    redirect_pc_o;
logic                   bp_update_o;
logic [`PC_BITS-1:0]    bp_pc_o;
logic [`PC_BITS-1:0]    bp_target_o;
logic                   bp_taken_o;
logic                   mem_valid_o;
logic [`PC_BITS-1:0]    mem_pc_o;
logic [`XLEN-1:0]       mem_result_o;
logic [`XLEN-1:0]       mem_rs2_o;
logic [`XLEN-1:0]       mem_alu_o;

integer seed;
int     errors;
int     tests;
int     cycles;

exec_clock u_clock (
    .clk_o  (clk),
    .rstn_o (rstn)
);

exec_stage dut_i (
    .clk_i            (clk),
    .rstn_i           (rstn),
    .uop_valid_i      (uop_valid),
    .uop_pc_i         (uop_pc),
    .uop_rs1_i        (uop_rs1),
    .uop_rs2_i        (uop_rs2),
    .uop_imm_i        (uop_imm),
    .uop_alu_op_i     (uop_alu_op),
    .uop_op1_sel_i    (uop_op1_sel),
    .uop_op2_sel_i    (uop_op2_sel),
    .uop_br_op_i      (uop_br_op),
    .uop_pred_taken_i (uop_pred_taken),
    .uop_wb_sel_i     (uop_wb_sel),
    .hold_i           (hold),
    .flush_i          (flush_in),
    .stall_o          (stall_o),
    .flush_o          (flush_o),
    .redirect_pc_o    (redirect_pc_o),
    .bp_update_o      (bp_update_o),
    .bp_pc_o          (bp_pc_o),
    .bp_target_o      (bp_target_o),
    .bp_taken_o       (bp_taken_o),
    .mem_valid_o      (mem_valid_o),
    .mem_pc_o         (mem_pc_o),
    .mem_result_o     (mem_result_o),
    .mem_rs2_o        (mem_rs2_o),
    .mem_alu_o        (mem_alu_o)
);

// ********************
// Reference model
// ********************

function automatic logic signed_less(input logic [`XLEN-1:0] a, b);
    return (a[`XLEN-1] != b[`XLEN-1]) ? a[`XLEN-1] : (a < b);   // Sign bits decide first
endfunction

function automatic logic [`XLEN-1:0] alu_model(input exec_pkg::alu_op_e op,
                                               input logic [`XLEN-1:0] a, b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
        exec_pkg::ALU_ADD:  return a + b;
        exec_pkg::ALU_SUB:  return a + ~b + 1;
        exec_pkg::ALU_AND:  return a & b;
        exec_pkg::ALU_OR:   return a | b;
        exec_pkg::ALU_XOR:  return a ^ b;
        exec_pkg::ALU_SLL:  return a << sh;
        exec_pkg::ALU_SRL:  return a >> sh;
        exec_pkg::ALU_SRA:  return (a >> sh) | (a[`XLEN-1] ? ~({`XLEN{1'b1}} >> sh) : '0);
        exec_pkg::ALU_SLT:  return `XLEN'(signed_less(a, b));
        exec_pkg::ALU_SLTU: return `XLEN'(a < b);
        default:            return 'x;
    endcase
endfunction

function automatic logic branch_taken(input exec_pkg::br_op_e br,
                                      input logic [`XLEN-1:0] a, b);
    case (br)
        exec_pkg::BR_BEQ:  return a == b;
        exec_pkg::BR_BNE:  return a != b;
        exec_pkg::BR_BLT:  return signed_less(a, b);
        exec_pkg::BR_BGE:  return !signed_less(a, b);
        exec_pkg::BR_BLTU: return a < b;
        exec_pkg::BR_BGEU: return a >= b;
        exec_pkg::BR_JAL,
        exec_pkg::BR_JALR: return 1'b1;
        default:           return 1'b0;
    endcase
endfunction

// ********************
// Helpers
// ********************

task automatic check_value(input string name, input logic [`XLEN-1:0] got, exp);
    assert (got === exp) else begin
        $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
        errors++;
    end
endtask

task automatic drive_uop(input logic valid, input logic [`XLEN-1:0] pc, rs1, rs2, imm,
                         input exec_pkg::alu_op_e op,
                         input exec_pkg::opnd_sel_e s1, s2,
                         input exec_pkg::br_op_e br, input logic pred,
                         input exec_pkg::wb_sel_e wb);
    uop_valid      = valid;
    uop_pc         = pc;
    uop_rs1        = rs1;
    uop_rs2        = rs2;
    uop_imm        = imm;
    uop_alu_op     = op;
    uop_op1_sel    = s1;
    uop_op2_sel    = s2;
    uop_br_op      = br;
    uop_pred_taken = pred;
    uop_wb_sel     = wb;
endtask

task automatic drive_idle();
    drive_uop(1'b0, '0, '0, '0, '0, exec_pkg::ALU_ADD, exec_pkg::OPND_ZERO,
              exec_pkg::OPND_ZERO, exec_pkg::BR_NONE, 1'b0, exec_pkg::WB_ALU);
endtask

// One uop through the register, checked one cycle later
task automatic issue_check(input logic [`XLEN-1:0] pc, rs1, rs2, imm,
                           input exec_pkg::alu_op_e op,
                           input exec_pkg::opnd_sel_e s1, s2,
                           input exec_pkg::wb_sel_e wb,
                           input logic [`XLEN-1:0] exp_result, exp_alu);
    drive_uop(1'b1, pc, rs1, rs2, imm, op, s1, s2, exec_pkg::BR_NONE, 1'b0, wb);
    @(negedge clk);
    check_value("mem_valid_o", mem_valid_o, 1);
    check_value("mem_pc_o", mem_pc_o, pc);
    check_value("mem_result_o", mem_result_o, exp_result);
    check_value("mem_rs2_o", mem_rs2_o, rs2);
    check_value("mem_alu_o", mem_alu_o, exp_alu);
endtask

task automatic finish_test(input string name, input int start_errors);
    tests++;
    if (errors == start_errors)
        $display("%-10s ok", name);
    else
        $display("%-10s %0d errors", name, errors - start_errors);
endtask

// ********************
// Tests
// ********************

task automatic test_reset();
    int start;
    start = errors;
    @(posedge rstn);
    #1;
    check_value("mem_valid_o", mem_valid_o, 0);
    check_value("stall_o", stall_o, 0);
    check_value("flush_o", flush_o, 0);
    check_value("bp_update_o", bp_update_o, 0);
    @(negedge clk);
    finish_test("reset", start);
endtask

task automatic test_alu();
    int start;
    exec_pkg::alu_op_e op;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    start = errors;
    for (int i = 0; i < 10; i++) begin
        for (int k = 0; k < 2; k++) begin
            op = exec_pkg::alu_op_e'(i);
            pc = $random(seed) & 32'hffff_fffc;
            a  = $random(seed);
            b  = $random(seed);
            issue_check(pc, a, b, '0, op, exec_pkg::OPND_RS1, exec_pkg::OPND_RS2,
                        exec_pkg::WB_ALU, alu_model(op, a, b), alu_model(op, a, b));
        end
    end
    drive_idle();
    @(negedge clk);
    finish_test("alu", start);
endtask

task automatic test_operands();
    int start;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] rs1;
    logic [`XLEN-1:0] rs2;
    logic [`XLEN-1:0] imm;
    start = errors;
    pc  = $random(seed) & 32'hffff_fffc;
    rs1 = $random(seed);
    rs2 = $random(seed);
    imm = $random(seed);
    issue_check(pc, rs1, rs2, imm, exec_pkg::ALU_ADD, exec_pkg::OPND_IMM, exec_pkg::OPND_PC,
                exec_pkg::WB_ALU, imm + pc, imm + pc);
    issue_check(pc, rs1, rs2, imm, exec_pkg::ALU_ADD, exec_pkg::OPND_ZERO, exec_pkg::OPND_RS2,
                exec_pkg::WB_OP1, '0, rs2);
    issue_check(pc, rs1, rs2, imm, exec_pkg::ALU_SUB, exec_pkg::OPND_PC, exec_pkg::OPND_IMM,
                exec_pkg::WB_OP1, pc, pc - imm);
    issue_check(pc, rs1, rs2, imm, exec_pkg::ALU_OR, exec_pkg::OPND_IMM, exec_pkg::OPND_ZERO,
                exec_pkg::WB_OP1, imm, imm);
    drive_idle();
    @(negedge clk);
    finish_test("operands", start);
endtask

task automatic test_branch();
    int start;
    exec_pkg::br_op_e  br;
    exec_pkg::wb_sel_e wb;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] target;
    logic [`XLEN-1:0] link;
    logic taken;
    start = errors;
    for (int i = 0; i < 9; i++) begin
        for (int k = 0; k < 2; k++) begin
            for (int p = 0; p < 2; p++) begin
                br  = exec_pkg::br_op_e'(i);
                pc  = $random(seed) & 32'hffff_fffc;
                a   = $random(seed);
                b   = (k == 0) ? a : $random(seed);     // Equal pair, then random pair
                imm = $random(seed);
                taken  = branch_taken(br, a, b);
                link   = pc + 4;
                target = (br == exec_pkg::BR_JALR) ? ((a + imm) & ~32'h1) : pc + imm;
                wb = (br == exec_pkg::BR_JAL || br == exec_pkg::BR_JALR) ?
                     exec_pkg::WB_LINK : exec_pkg::WB_ALU;
                drive_uop(1'b1, pc, a, b, imm, exec_pkg::ALU_ADD, exec_pkg::OPND_RS1,
                          exec_pkg::OPND_RS2, br, p[0], wb);
                #1;
                check_value("flush_o", flush_o, taken != p[0]);
                check_value("redirect_pc_o", redirect_pc_o, taken ? target : link);
                check_value("bp_update_o", bp_update_o, br != exec_pkg::BR_NONE);
                if (br != exec_pkg::BR_NONE) begin
                    check_value("bp_pc_o", bp_pc_o, pc);
                    check_value("bp_target_o", bp_target_o, target);
                    check_value("bp_taken_o", bp_taken_o, taken);
                end
                @(negedge clk);
                check_value("mem_valid_o", mem_valid_o, 1);
                check_value("mem_result_o", mem_result_o,
                            (wb == exec_pkg::WB_LINK) ? link : a + b);
            end
        end
    end
    drive_idle();
    @(negedge clk);
    finish_test("branch", start);
endtask

task automatic test_multiply();
    int start;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    start = errors;
    for (int n = 0; n < 6; n++) begin
        a = $random(seed);
        b = (n == 0) ? 32'd0 : (n == 1) ? 32'd1 : $random(seed);
        drive_uop(1'b1, 32'h0000_1000 + 4 * n, a, b, '0, exec_pkg::ALU_ADD,
                  exec_pkg::OPND_RS1, exec_pkg::OPND_RS2, exec_pkg::BR_NONE, 1'b0,
                  exec_pkg::WB_MUL);
        #1;
        check_value("stall_o", stall_o, 1);
        while (stall_o) begin                   // Uop held while the multiplier runs
            check_value("mem_valid_o", mem_valid_o, 0);
            @(negedge clk);
        end
        @(negedge clk);
        drive_idle();
        check_value("mem_valid_o", mem_valid_o, 1);
        check_value("mem_result_o", mem_result_o, a * b);
        check_value("mem_alu_o", mem_alu_o, a + b);
        @(negedge clk);
        check_value("mem_valid_o", mem_valid_o, 0);
    end
    finish_test("multiply", start);
endtask

task automatic test_backpressure();
    int start;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    start = errors;
    a = $random(seed);
    b = $random(seed);
    issue_check(32'h0000_2000, a, b, '0, exec_pkg::ALU_ADD, exec_pkg::OPND_RS1,
                exec_pkg::OPND_RS2, exec_pkg::WB_ALU, a + b, a + b);
    hold = 1'b1;
    for (int n = 0; n < 3; n++) begin
        drive_uop(n != 1, $random(seed), $random(seed), $random(seed), '0,
                  exec_pkg::ALU_XOR, exec_pkg::OPND_RS1, exec_pkg::OPND_RS2,
                  exec_pkg::BR_NONE, 1'b0, exec_pkg::WB_ALU);    // Bubble in the middle
        @(negedge clk);
        check_value("mem_valid_o", mem_valid_o, 1);
        check_value("mem_pc_o", mem_pc_o, 32'h0000_2000);
        check_value("mem_result_o", mem_result_o, a + b);
        check_value("mem_rs2_o", mem_rs2_o, b);
        check_value("mem_alu_o", mem_alu_o, a + b);
    end
    hold     = 1'b0;
    flush_in = 1'b1;
    @(negedge clk);
    check_value("mem_valid_o", mem_valid_o, 0);
    flush_in = 1'b0;
    @(negedge clk);
    check_value("mem_valid_o", mem_valid_o, 1);
    hold     = 1'b1;                            // Flush together with hold
    flush_in = 1'b1;
    @(negedge clk);
    check_value("mem_valid_o", mem_valid_o, 0);
    hold     = 1'b0;
    flush_in = 1'b0;
    drive_idle();
    @(negedge clk);
    finish_test("backpress", start);
endtask

// ********************
// Run control
// ********************

always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_MAX) begin
        $display("Timeout: cycle limit of %0d reached before the tests ended", CYCLE_MAX);
        $display("Test failures found");
        $finish;
    end
end

initial begin
    seed     = 32'h7b42_fe79;
    errors   = 0;
    tests    = 0;
    cycles   = 0;
    hold     = 1'b0;
    flush_in = 1'b0;
    drive_idle();
    test_reset();
    test_alu();
    test_operands();
    test_branch();
    test_multiply();
    test_backpressure();
    $display("Summary: %0d tests run, %0d failed checks", tests, errors);
    if (errors == 0)
        $display("All tests passed!");
    else
        $display("Test failures found");
    $finish;
end

endmodule

`default_nettype wire

/* exec_stage.f */
+incdir+rtl
rtl/exec_pkg.sv
rtl/uop_decode.sv
rtl/alu.sv
rtl/mul_unit.sv
rtl/branch_unit.sv
rtl/exec_result.sv
rtl/exec_stage.sv
bench/exec_clock.sv
bench/exec_stage_tb.sv
